// File: proc_pkg.sv
/*
 * Shared types for the five-stage 16-bit pipeline.
 * Opcodes, ALU functions, the instruction word views and the stage registers.
 */
`default_nettype none

package proc_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_sel_t;

	// ADD, SUB and AND all use RFMT_OP and are told apart by funct
	typedef enum logic [4:0] {
		HALT_OP = 5'b00000,
		NOP_OP  = 5'b00001,
		ADDI_OP = 5'b01000,
		BEQZ_OP = 5'b01100,
		ST_OP   = 5'b10000,
		LD_OP   = 5'b10001,
		RFMT_OP = 5'b11011
	} opcode_e;

	// Doubles as the R-format funct field, 2'b11 is not an instruction
	typedef enum logic [1:0] {
		ALU_ADD = 2'b00,
		ALU_SUB = 2'b01,
		ALU_AND = 2'b10
	} alu_fn_e;

	typedef struct packed {
		opcode_e  op;
		reg_sel_t rs;
		reg_sel_t rt;
		reg_sel_t rd;
		alu_fn_e  funct;
	} r_fmt_t;

	// For ST the rd field names the register holding the store data
	typedef struct packed {
		opcode_e    op;
		reg_sel_t   rs;
		reg_sel_t   rd;
		logic [4:0] imm5;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	// Byte addressed, one instruction is two bytes
	localparam word_t PC_STEP = 16'd2;

	typedef struct packed {
		logic   valid;
		word_t  pc_next;
		instr_u instr;
	} fd_t;

	typedef struct packed {
		logic     valid;
		logic     halt;
		word_t    pc_next;
		word_t    rs_val;
		word_t    rt_val;
		word_t    imm;
		alu_fn_e  alu_fn;
		logic     use_imm;
		logic     branch;
		logic     mem_en;
		logic     mem_wr;
		logic     reg_wr;
		reg_sel_t wr_sel;
	} de_t;

	typedef struct packed {
		logic     valid;
		logic     halt;
		word_t    alu_out;
		word_t    store_val;
		logic     mem_en;
		logic     mem_wr;
		logic     reg_wr;
		reg_sel_t wr_sel;
	} em_t;

	typedef struct packed {
		logic     valid;
		reg_sel_t wr_sel;
		word_t    data;
	} wb_t;

	typedef struct packed {
		logic  take;
		word_t target;
	} redirect_t;

endpackage

`default_nettype wire

// File: fetch.sv
/*
 * Fetch stage with the program counter and instruction memory.
 * Also holds the fetch/decode register.
 */
`default_nettype none

module fetch import proc_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      load_en,
	input  word_t     load_addr,
	input  word_t     load_data,
	input  logic      run,
	input  logic      stall,
	input  logic      stop,
	input  redirect_t redirect,
	output fd_t       fd
);

	word_t pc;
	word_t imem [IMEM_WORDS];

	// Load port takes a byte address like the PC
	always_ff @(posedge clk) begin
		if (load_en)
			imem[load_addr[$clog2(IMEM_WORDS):1]] <= load_data;
	end

	// Redirect beats stop, stop beats stall, stall beats run
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			fd.valid <= 1'b0;
		end else if (redirect.take) begin
			pc <= redirect.target;
			fd.valid <= 1'b0;
		end else if (stop) begin
			fd.valid <= 1'b0;
		end else if (stall) begin
			// Hold PC and fd
		end else if (run) begin
			pc <= pc + PC_STEP;
			fd.valid <= 1'b1;
			fd.pc_next <= pc + PC_STEP;
			fd.instr <= imem[pc[$clog2(IMEM_WORDS):1]];
		end else begin
			fd.valid <= 1'b0;
		end
	end

	// Branch targets come from execute, odd offsets would break this
	pc_even: assert property (@(posedge clk) disable iff (reset) !pc[0]);

endmodule

`default_nettype wire

// File: decode.sv
/*
 * Decode stage with the register file, control decode and hazard stall.
 * Also holds the decode/execute register and the sticky error level.
 */
`default_nettype none

module decode import proc_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  fd_t       fd,
	input  redirect_t redirect,
	input  wb_t       wb,
	output logic      stall,
	output de_t       de,
	input  em_t       em_dest,
	output logic      err
);

	word_t    regs [8];
	instr_u   ins;
	reg_sel_t rs;
	reg_sel_t rt;
	word_t    rs_val;
	word_t    rt_val;
	de_t      nxt;
	logic     legal;
	logic     use_rs;
	logic     use_rt;
	logic     halt_seen;
	logic     fd_ok;
	logic     issue;

	// True when a register write to r is still in flight
	function automatic logic busy(reg_sel_t r, de_t d, em_t e, wb_t w);
		return (d.valid && d.reg_wr && d.wr_sel == r) ||
			(e.valid && e.reg_wr && e.wr_sel == r) ||
			(w.valid && w.wr_sel == r);
	endfunction

	assign ins = fd.instr;
	assign rs = ins.r.rs;
	assign rt = ins.r.rt;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (wb.valid) begin
			regs[wb.wr_sel] <= wb.data;
		end
	end

	// Same-cycle write passes straight to the read ports
	assign rs_val = (wb.valid && wb.wr_sel == rs) ? wb.data : regs[rs];
	assign rt_val = (wb.valid && wb.wr_sel == rt) ? wb.data : regs[rt];

	always_comb begin
		nxt = '0;
		nxt.pc_next = fd.pc_next;
		nxt.rs_val = rs_val;
		nxt.rt_val = rt_val;
		nxt.imm = {{11{ins.i.imm5[4]}}, ins.i.imm5};
		nxt.wr_sel = ins.i.rd;
		legal = 1'b1;
		use_rs = 1'b0;
		use_rt = 1'b0;
		case (ins.r.op)
			RFMT_OP: begin
				nxt.alu_fn = ins.r.funct;
				nxt.reg_wr = 1'b1;
				nxt.wr_sel = ins.r.rd;
				use_rs = 1'b1;
				use_rt = 1'b1;
				if (ins.r.funct == 2'b11)
					legal = 1'b0;
			end
			ADDI_OP, LD_OP: begin
				nxt.use_imm = 1'b1;
				nxt.reg_wr = 1'b1;
				nxt.mem_en = (ins.i.op == LD_OP);
				use_rs = 1'b1;
			end
			ST_OP: begin
				nxt.use_imm = 1'b1;
				nxt.mem_en = 1'b1;
				nxt.mem_wr = 1'b1;
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			BEQZ_OP: begin
				nxt.branch = 1'b1;
				use_rs = 1'b1;
			end
			HALT_OP: nxt.halt = 1'b1;
			NOP_OP: ;
			default: legal = 1'b0;
		endcase
	end

	// Nothing younger than a HALT or a bad opcode gets past decode
	assign fd_ok = fd.valid && !err && !halt_seen;
	assign stall = fd_ok && legal &&
		((use_rs && busy(rs, de, em_dest, wb)) || (use_rt && busy(rt, de, em_dest, wb)));
	assign issue = fd_ok && legal && !stall && !redirect.take;

	always_ff @(posedge clk) begin
		if (reset) begin
			de.valid <= 1'b0;
			err <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			de <= nxt;
			de.valid <= issue;
			if (fd_ok && !legal && !redirect.take)
				err <= 1'b1;
			if (issue && nxt.halt)
				halt_seen <= 1'b1;
		end
	end

	// Both younger instructions are gone after a taken branch
	flush_or_stall_bubble: assert property (@(posedge clk) disable iff (reset)
		redirect.take |=> (!fd.valid && !de.valid));

	// A stalled instruction waits at the decode input behind a bubble
	stall_holds_fd: assert property (@(posedge clk) disable iff (reset)
		(stall && !redirect.take) |=> ($stable(fd) && !de.valid));

endmodule

`default_nettype wire

// File: execute.sv
/*
 * Execute stage with the ALU and BEQZ resolution.
 * Drives the branch redirect and holds the execute/memory register.
 */
`default_nettype none

module execute import proc_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  de_t       de,
	output redirect_t redirect,
	output em_t       em
);

	word_t opb;
	word_t alu;

	assign opb = de.use_imm ? de.imm : de.rt_val;

	// SUB is rs minus the second operand
	always_comb begin
		case (de.alu_fn)
			ALU_ADD: alu = de.rs_val + opb;
			ALU_SUB: alu = de.rs_val - opb;
			ALU_AND: alu = de.rs_val & opb;
			default: alu = de.rs_val + opb;
		endcase
	end

	// Taken when rs is zero, target relative to the next instruction
	assign redirect.take = de.valid && de.branch && (de.rs_val == '0);
	assign redirect.target = de.pc_next + de.imm;

	always_ff @(posedge clk) begin
		if (reset) begin
			em.valid <= 1'b0;
		end else begin
			em.valid <= de.valid && !redirect.take;
			em.halt <= de.halt;
			em.alu_out <= alu;
			em.store_val <= de.rt_val;
			em.mem_en <= de.mem_en;
			em.mem_wr <= de.mem_wr;
			em.reg_wr <= de.reg_wr;
			em.wr_sel <= de.wr_sel;
		end
	end

endmodule

`default_nettype wire

// File: memory.sv
/*
 * Memory stage with the data memory and writeback select.
 * Holds the memory/writeback register and the halted level.
 */
`default_nettype none

module memory import proc_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  em_t  em,
	output wb_t  wb,
	output logic halted
);

	word_t dmem [DMEM_WORDS];
	logic [$clog2(DMEM_WORDS)-1:0] idx;
	word_t rdata;
	logic  is_load;

	// Word address from the byte address
	assign idx = em.alu_out[$clog2(DMEM_WORDS):1];
	assign rdata = dmem[idx];
	assign is_load = em.mem_en && !em.mem_wr;

	always_ff @(posedge clk) begin
		if (em.valid && em.mem_en && em.mem_wr)
			dmem[idx] <= em.store_val;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb.valid <= 1'b0;
			halted <= 1'b0;
		end else begin
			wb.valid <= em.valid && em.reg_wr;
			wb.wr_sel <= em.wr_sel;
			wb.data <= is_load ? rdata : em.alu_out;
			if (em.valid && em.halt)
				halted <= 1'b1;
		end
	end

	// Store address is rs plus imm from upstream
	store_aligned: assert property (@(posedge clk) disable iff (reset)
		(em.valid && em.mem_en && em.mem_wr) |-> !em.alu_out[0]);

endmodule

`default_nettype wire

// File: proc.sv
/*
 * Top level of the pipeline, wiring fetch, decode, execute and memory.
 */
`default_nettype none

module proc import proc_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  load_en,
	input  word_t load_addr,
	input  word_t load_data,
	input  logic  run,
	output wb_t   wb,
	output logic  halted,
	output logic  err
);

	fd_t       fd;
	de_t       de;
	em_t       em;
	redirect_t redirect;
	logic      stall;
	logic      stop;

	// Either sticky level ends instruction issue
	assign stop = halted | err;

	fetch u_fetch (
		.clk       (clk),
		.reset     (reset),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.run       (run),
		.stall     (stall),
		.stop      (stop),
		.redirect  (redirect),
		.fd        (fd)
	);

	decode u_decode (
		.clk      (clk),
		.reset    (reset),
		.fd       (fd),
		.redirect (redirect),
		.wb       (wb),
		.stall    (stall),
		.de       (de),
		.em_dest  (em),
		.err      (err)
	);

	execute u_execute (
		.clk      (clk),
		.reset    (reset),
		.de       (de),
		.redirect (redirect),
		.em       (em)
	);

	memory u_memory (
		.clk    (clk),
		.reset  (reset),
		.em     (em),
		.wb     (wb),
		.halted (halted)
	);

endmodule

`default_nettype wire

// File: proc_tb_clock.sv
/*
 * Clock and power-on reset for the processor testbench.
 */
`default_nettype none

module proc_tb_clock (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: proc_tb.sv
/*
 * Testbench for the pipelined processor.
 * Program table, instruction loader, writeback collector and checks.
 */
`default_nettype none

module proc_tb import proc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_ROWS = 10;
	localparam int ROW_WORDS = 8;
	localparam int ROW_TIMEOUT = 200;
	localparam int DRAIN_CYCLES = 8;

	logic  clk;
	logic  por_reset;
	logic  row_reset;
	logic  reset;
	logic  load_en;
	word_t load_addr;
	word_t load_data;
	logic  run;
	wb_t   wb;
	logic  halted;
	logic  err;

	// One row per program, expected writebacks in program order
	word_t    prog [MAX_ROWS][ROW_WORDS];
	reg_sel_t exp_sel [MAX_ROWS][ROW_WORDS];
	word_t    exp_data [MAX_ROWS][ROW_WORDS];
	int       exp_n [MAX_ROWS];
	logic     exp_halted [MAX_ROWS];
	logic     exp_err [MAX_ROWS];
	string    row_name [MAX_ROWS];
	int       nrows;
	int       nwords;
	int       errors;
	integer   seed;

	reg_sel_t got_sel [$];
	word_t    got_data [$];

	proc_tb_clock clock_i (
		.clk   (clk),
		.reset (por_reset)
	);

	assign reset = por_reset | row_reset;

	proc dut_i (
		.clk       (clk),
		.reset     (reset),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.run       (run),
		.wb        (wb),
		.halted    (halted),
		.err       (err)
	);

	function automatic word_t encode_r(alu_fn_e fn, reg_sel_t rs, reg_sel_t rt, reg_sel_t rd);
		return {RFMT_OP, rs, rt, rd, fn};
	endfunction

	function automatic word_t encode_i(opcode_e op, reg_sel_t rs, reg_sel_t rd, int imm);
		return {op, rs, rd, imm[4:0]};
	endfunction

	// Two's complement value of imm5 as a 16-bit word
	function automatic word_t sext5(logic [4:0] imm);
		int v;
		v = imm;
		if (v > 15)
			v -= 32;
		return word_t'(v);
	endfunction

	task automatic check(string name, word_t actual, word_t expected);
		if (actual !== expected) begin
			errors++;
			$display("Error: %s is %h, expected %h", name, actual, expected);
		end
	endtask

	// Unused slots stay zero and decode as HALT
	task automatic begin_row(string name, logic halt_lvl, logic err_lvl);
		row_name[nrows] = name;
		exp_halted[nrows] = halt_lvl;
		exp_err[nrows] = err_lvl;
		exp_n[nrows] = 0;
		nwords = 0;
		for (int k = 0; k < ROW_WORDS; k++)
			prog[nrows][k] = '0;
	endtask

	task automatic add_instr(word_t w);
		prog[nrows][nwords] = w;
		nwords++;
	endtask

	task automatic expect_wb(reg_sel_t sel, word_t data);
		exp_sel[nrows][exp_n[nrows]] = sel;
		exp_data[nrows][exp_n[nrows]] = data;
		exp_n[nrows]++;
	endtask

	task automatic build_table();
		int ra;
		int rb;
		begin_row("alu chain", 1'b1, 1'b0);
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd1, 13));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd2, 7));
		add_instr(encode_r(ALU_ADD, 3'd1, 3'd2, 3'd3));
		add_instr(encode_r(ALU_SUB, 3'd3, 3'd2, 3'd4));
		add_instr(encode_r(ALU_AND, 3'd4, 3'd3, 3'd5));
		add_instr(encode_r(ALU_SUB, 3'd2, 3'd3, 3'd6));
		add_instr(encode_i(HALT_OP, 3'd0, 3'd0, 0));
		expect_wb(3'd1, 16'h000D);
		expect_wb(3'd2, 16'h0007);
		expect_wb(3'd3, 16'h0014);
		expect_wb(3'd4, 16'h000D);
		expect_wb(3'd5, 16'h0004);
		expect_wb(3'd6, 16'hFFF3);
		nrows++;
		begin_row("addi sign", 1'b1, 1'b0);
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd1, -1));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd2, -16));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd3, 15));
		add_instr(encode_i(ADDI_OP, 3'd3, 3'd4, -16));
		add_instr(encode_i(ADDI_OP, 3'd1, 3'd5, 2));
		add_instr(encode_i(HALT_OP, 3'd0, 3'd0, 0));
		expect_wb(3'd1, 16'hFFFF);
		expect_wb(3'd2, 16'hFFF0);
		expect_wb(3'd3, 16'h000F);
		expect_wb(3'd4, 16'hFFFF);
		expect_wb(3'd5, 16'h0001);
		nrows++;
		// Store r1 to r2 + 2, then load it back into r3
		begin_row("store load", 1'b1, 1'b0);
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd1, 9));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd2, 4));
		add_instr(encode_i(ST_OP, 3'd2, 3'd1, 2));
		add_instr(encode_i(LD_OP, 3'd2, 3'd3, 2));
		add_instr(encode_r(ALU_ADD, 3'd3, 3'd1, 3'd4));
		add_instr(encode_i(HALT_OP, 3'd0, 3'd0, 0));
		expect_wb(3'd1, 16'h0009);
		expect_wb(3'd2, 16'h0004);
		expect_wb(3'd3, 16'h0009);
		expect_wb(3'd4, 16'h0012);
		nrows++;
		// Target is 4 + 4 and skips the two ADDIs in between
		begin_row("beqz taken", 1'b1, 1'b0);
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd1, 1));
		add_instr(encode_i(BEQZ_OP, 3'd0, 3'd0, 4));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd2, 7));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd3, 7));
		add_instr(encode_i(ADDI_OP, 3'd1, 3'd4, 2));
		add_instr(encode_i(HALT_OP, 3'd0, 3'd0, 0));
		expect_wb(3'd1, 16'h0001);
		expect_wb(3'd4, 16'h0003);
		nrows++;
		begin_row("beqz not taken", 1'b1, 1'b0);
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd1, 1));
		add_instr(encode_i(BEQZ_OP, 3'd1, 3'd0, 4));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd2, 7));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd3, 6));
		add_instr(encode_i(HALT_OP, 3'd0, 3'd0, 0));
		expect_wb(3'd1, 16'h0001);
		expect_wb(3'd2, 16'h0007);
		expect_wb(3'd3, 16'h0006);
		nrows++;
		begin_row("halt", 1'b1, 1'b0);
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd1, 2));
		add_instr(encode_i(ADDI_OP, 3'd1, 3'd2, 3));
		add_instr(encode_i(HALT_OP, 3'd0, 3'd0, 0));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd3, 1));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd4, 1));
		expect_wb(3'd1, 16'h0002);
		expect_wb(3'd2, 16'h0005);
		nrows++;
		begin_row("illegal op", 1'b0, 1'b1);
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd1, 4));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd2, 5));
		// Opcode 5'b11111 is not defined
		add_instr(16'hF800);
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd3, 6));
		add_instr(encode_i(ADDI_OP, 3'd0, 3'd4, 7));
		add_instr(encode_i(HALT_OP, 3'd0, 3'd0, 0));
		expect_wb(3'd1, 16'h0004);
		expect_wb(3'd2, 16'h0005);
		nrows++;
		for (int n = 0; n < 2; n++) begin
			ra = $random(seed);
			rb = $random(seed);
			begin_row($sformatf("random add %0d", n), 1'b1, 1'b0);
			add_instr(encode_i(ADDI_OP, 3'd0, 3'd1, ra));
			add_instr(encode_i(ADDI_OP, 3'd0, 3'd2, rb));
			add_instr(encode_r(ALU_ADD, 3'd1, 3'd2, 3'd3));
			add_instr(encode_i(HALT_OP, 3'd0, 3'd0, 0));
			expect_wb(3'd1, sext5(ra[4:0]));
			expect_wb(3'd2, sext5(rb[4:0]));
			expect_wb(3'd3, sext5(ra[4:0]) + sext5(rb[4:0]));
			nrows++;
		end
	endtask

	task automatic collect();
		if (wb.valid) begin
			got_sel.push_back(wb.wr_sel);
			got_data.push_back(wb.data);
		end
	endtask

	task automatic run_row(int r);
		int cycles;
		bit stopped;
		got_sel.delete();
		got_data.delete();
		@(posedge clk);
		row_reset <= 1'b1;
		run <= 1'b0;
		repeat (2) @(posedge clk);
		row_reset <= 1'b0;
		for (int k = 0; k < ROW_WORDS; k++) begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= word_t'(2 * k);
			load_data <= prog[r][k];
		end
		@(posedge clk);
		load_en <= 1'b0;
		run <= 1'b1;
		cycles = 0;
		stopped = 1'b0;
		while (!stopped && cycles < ROW_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			collect();
			stopped = halted || err;
		end
		if (!stopped) begin
			errors++;
			$display("Row %s timed out, neither halted nor err went high", row_name[r]);
		end
		// Older instructions may still be in flight after err
		for (int k = 0; k < DRAIN_CYCLES; k++) begin
			@(negedge clk);
			collect();
		end
		if (got_sel.size() != exp_n[r]) begin
			errors++;
			$display("Row %s gave %0d writebacks instead of %0d", row_name[r],
				got_sel.size(), exp_n[r]);
		end
		for (int i = 0; i < exp_n[r] && i < got_sel.size(); i++) begin
			check($sformatf("%s wb[%0d].wr_sel", row_name[r], i),
				word_t'(got_sel[i]), word_t'(exp_sel[r][i]));
			check($sformatf("%s wb[%0d].data", row_name[r], i),
				got_data[i], exp_data[r][i]);
		end
		check($sformatf("%s halted", row_name[r]), word_t'(halted), word_t'(exp_halted[r]));
		check($sformatf("%s err", row_name[r]), word_t'(err), word_t'(exp_err[r]));
	endtask

	initial begin
		row_reset = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		run = 1'b0;
		errors = 0;
		nrows = 0;
		seed = 72;
		build_table();
		for (int r = 0; r < nrows; r++)
			run_row(r);
		$display("Rows run: %0d, errors: %0d", nrows, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
proc_pkg.sv
fetch.sv
decode.sv
execute.sv
memory.sv
proc.sv
proc_tb_clock.sv
proc_tb.sv

// File: Bender.yml
package:
  name: proc

sources:
  - proc_pkg.sv
  - fetch.sv
  - decode.sv
  - execute.sv
  - memory.sv
  - proc.sv
  - target: test
    files:
      - proc_tb_clock.sv
      - proc_tb.sv
